/* build.f */
design/isaPkg.sv
design/cpuPkg.sv
design/cycleSequencer.sv
design/fetchUnit.sv
design/decodeUnit.sv
design/registerFile.sv
design/aluExecute.sv
design/memoryAccess.sv
design/writebackUnit.sv
design/mipsCpuBus.sv
test/avalonMemory.sv
test/cpuTb.sv

/* design/aluExecute.sv */
module aluExecute
    import cpuPkg::*;
    import isaPkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  cycleState                 state,
    input  opCode                     opcode,
    input  fnCode                     funct,
    input  aluOp                      aluControl,
    input  logic [dataWidth-1:0]      rsData,
    input  logic [dataWidth-1:0]      rtData,
    input  logic [dataWidth-1:0]      immSigned,
    input  logic [dataWidth-1:0]      immZero,
    input  logic [4:0]                shamt,
    input  logic [jumpIndexWidth-1:0] jumpIndex,
    input  logic [dataWidth-1:0]      pc,
    output logic [dataWidth-1:0]      aluResult,
    output logic                      redirect,
    output logic [dataWidth-1:0]      redirectTarget
);

    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] aluOut;
    logic [dataWidth-1:0] pcPlus4;
    logic [dataWidth-1:0] jumpTarget;
    logic [dataWidth-1:0] branchTarget;
    logic                 operandsEqual;

    always_comb begin
        case (opcode)
            OP_ANDI, OP_ORI, OP_XORI:     opB = immZero;
            OP_R_TYPE, OP_BEQ, OP_BNE:    opB = rtData;
            default:                      opB = immSigned;
        endcase
    end

    always_comb begin
        case (aluControl)
            ALU_AND:  aluOut = rsData & opB;
            ALU_OR:   aluOut = rsData | opB;
            ALU_XOR:  aluOut = rsData ^ opB;
            ALU_LUI:  aluOut = {opB[15:0], 16'h0000};
            ALU_ADD:  aluOut = rsData + opB;
            ALU_SUB:  aluOut = rsData - opB;
            ALU_SLT:  aluOut = {31'd0, $signed(rsData) < $signed(opB)};
            ALU_SLTU: aluOut = {31'd0, rsData < opB};
            ALU_SLL:  aluOut = opB << shamt;
            ALU_SRL:  aluOut = opB >> shamt;
            ALU_SRA:  aluOut = $signed(opB) >>> shamt;
            default:  aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) aluResult <= '0;
        else if (state == S_EXECUTE) aluResult <= aluOut;
    end

    assign pcPlus4 = pc + 32'd4;
    assign jumpTarget = {pcPlus4[31:28], jumpIndex, 2'b00};
    assign branchTarget = pcPlus4 + {immSigned[29:0], 2'b00};
    assign operandsEqual = (rsData == rtData);

    // one-cycle pulse, picked up by the fetch unit
    always_comb begin
        redirect = 1'b0;
        redirectTarget = jumpTarget;
        if (state == S_EXECUTE) begin
            case (opcode)
                OP_J, OP_JAL: redirect = 1'b1;
                OP_BEQ: begin
                    redirect = operandsEqual;
                    redirectTarget = branchTarget;
                end
                OP_BNE: begin
                    redirect = !operandsEqual;
                    redirectTarget = branchTarget;
                end
                OP_R_TYPE: begin
                    redirect = (funct == FN_JR);
                    redirectTarget = rsData;
                end
                default: redirect = 1'b0;
            endcase
        end
    end

endmodule

/* design/cpuPkg.sv */
package cpuPkg;

    // current stage of the multicycle sequence
    typedef enum logic [2:0] {
        S_FETCH     = 3'b000,
        S_DECODE    = 3'b001,
        S_EXECUTE   = 3'b010,
        S_MEMORY    = 3'b011,
        S_WRITEBACK = 3'b100,
        S_HALTED    = 3'b111
    } cycleState;

    // progress of a pending jump or branch across its delay slot
    typedef enum logic [1:0] {
        RD_NONE  = 2'b00,
        RD_ARMED = 2'b01,   // target captured while the branch instruction retires
        RD_SLOT  = 2'b10    // delay slot in flight
    } redirectState;

    localparam int dataWidth = 32;
    localparam logic [dataWidth-1:0] resetVector = 32'hBFC0_0000;
    localparam logic [dataWidth-1:0] haltAddress = 32'h0000_0000;
    localparam logic [4:0] linkRegister = 5'd31;  // $ra
    localparam logic [3:0] allLanes = 4'b1111;

endpackage

/* design/cycleSequencer.sv */
module cycleSequencer
    import cpuPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      waitrequest,
    input  logic      haltFetch,
    input  logic      memStall,
    output cycleState state,
    output logic      active
);

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= S_FETCH;
            active <= 1'b1;
        end else begin
            case (state)
                S_FETCH: begin
                    if (haltFetch) begin
                        state  <= S_HALTED;   // fetch from address zero ends the run
                        active <= 1'b0;
                    end else if (!waitrequest) begin
                        state <= S_DECODE;
                    end
                end
                S_DECODE:    state <= S_EXECUTE;
                S_EXECUTE:   state <= S_MEMORY;
                S_MEMORY:    if (!memStall) state <= S_WRITEBACK;
                S_WRITEBACK: state <= S_FETCH;
                default:     state <= S_HALTED;   // halted stays halted
            endcase
        end
    end

    // only reset brings the CPU back out of halt
    haltIsFinal: assert property (@(posedge clk) disable iff (reset)
        state == S_HALTED |=> state == S_HALTED && !active);

endmodule

/* design/decodeUnit.sv */
module decodeUnit
    import cpuPkg::*;
    import isaPkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  cycleState                 state,
    input  logic [dataWidth-1:0]      readdata,
    output opCode                     opcode,
    output fnCode                     funct,
    output logic [regAddrWidth-1:0]   rsAddr,
    output logic [regAddrWidth-1:0]   rtAddr,
    output logic [regAddrWidth-1:0]   rdAddr,
    output logic [4:0]                shamt,
    output logic [dataWidth-1:0]      immSigned,
    output logic [dataWidth-1:0]      immZero,
    output logic [jumpIndexWidth-1:0] jumpIndex,
    output aluOp                      aluControl
);

    function automatic aluOp selectAlu(opCode op, fnCode fn);
        aluOp sel;
        sel = ALU_DEFAULT;
        if (op == OP_R_TYPE) begin
            case (fn)
                FN_SLL:  sel = ALU_SLL;
                FN_SRL:  sel = ALU_SRL;
                FN_SRA:  sel = ALU_SRA;
                FN_ADDU: sel = ALU_ADD;
                FN_SUBU: sel = ALU_SUB;
                FN_AND:  sel = ALU_AND;
                FN_OR:   sel = ALU_OR;
                FN_XOR:  sel = ALU_XOR;
                FN_SLT:  sel = ALU_SLT;
                FN_SLTU: sel = ALU_SLTU;
                default: sel = ALU_DEFAULT;   // JR and unsupported codes
            endcase
        end else begin
            case (op)
                OP_BEQ, OP_BNE:        sel = ALU_SUB;
                OP_ADDIU, OP_LW, OP_SW: sel = ALU_ADD;   // address = base + offset
                OP_SLTI:               sel = ALU_SLT;
                OP_SLTIU:              sel = ALU_SLTU;
                OP_ANDI:               sel = ALU_AND;
                OP_ORI:                sel = ALU_OR;
                OP_XORI:               sel = ALU_XOR;
                OP_LUI:                sel = ALU_LUI;
                default:               sel = ALU_DEFAULT;
            endcase
        end
        return sel;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            opcode     <= OP_R_TYPE;
            funct      <= FN_SLL;
            aluControl <= ALU_DEFAULT;
        end else if (state == S_DECODE) begin
            opcode     <= opCode'(readdata[31:26]);
            funct      <= fnCode'(readdata[5:0]);
            aluControl <= selectAlu(opCode'(readdata[31:26]), fnCode'(readdata[5:0]));
        end
    end

    // operand fields and extended immediates
    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            rsAddr    <= readdata[25:21];
            rtAddr    <= readdata[20:16];
            rdAddr    <= readdata[15:11];
            shamt     <= readdata[10:6];
            immSigned <= {{(dataWidth-immWidth){readdata[immWidth-1]}}, readdata[immWidth-1:0]};
            immZero   <= {{(dataWidth-immWidth){1'b0}}, readdata[immWidth-1:0]};
            jumpIndex <= readdata[jumpIndexWidth-1:0];
        end
    end

endmodule

/* design/fetchUnit.sv */
module fetchUnit
    import cpuPkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  cycleState            state,
    input  logic                 redirect,
    input  logic [dataWidth-1:0] redirectTarget,
    output logic [dataWidth-1:0] pc,
    output logic                 haltFetch
);

    redirectState   rdState;
    logic [dataWidth-1:0] target;   // held until the delay slot has retired

    assign haltFetch = (state == S_FETCH) && (pc == haltAddress);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= resetVector;
            rdState <= RD_NONE;
        end else if (redirect) begin
            rdState <= RD_ARMED;
        end else if (state == S_WRITEBACK) begin
            case (rdState)
                RD_ARMED: begin
                    rdState <= RD_SLOT;
                    pc      <= pc + 32'd4;   // step into the delay slot
                end
                RD_SLOT: begin
                    rdState <= RD_NONE;
                    pc      <= target;
                end
                default: pc <= pc + 32'd4;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (redirect) target <= redirectTarget;
    end

    // jump and branch targets come from the execute stage
    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

/* design/isaPkg.sv */
package isaPkg;

    localparam int regAddrWidth = 5;
    localparam int immWidth = 16;
    localparam int jumpIndexWidth = 26;

    // primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_R_TYPE = 6'b000000,
        OP_J      = 6'b000010,
        OP_JAL    = 6'b000011,
        OP_BEQ    = 6'b000100,
        OP_BNE    = 6'b000101,
        OP_ADDIU  = 6'b001001,
        OP_SLTI   = 6'b001010,
        OP_SLTIU  = 6'b001011,
        OP_ANDI   = 6'b001100,
        OP_ORI    = 6'b001101,
        OP_XORI   = 6'b001110,
        OP_LUI    = 6'b001111,
        OP_LW     = 6'b100011,
        OP_SW     = 6'b101011
    } opCode;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_JR   = 6'b001000,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } fnCode;

    typedef enum logic [3:0] {
        ALU_AND     = 4'b0000,
        ALU_OR      = 4'b0001,
        ALU_XOR     = 4'b0010,
        ALU_LUI     = 4'b0011,
        ALU_ADD     = 4'b0100,
        ALU_SUB     = 4'b0101,
        ALU_SLTU    = 4'b0110,
        ALU_SLL     = 4'b1000,
        ALU_SRL     = 4'b1001,
        ALU_SRA     = 4'b1100,
        ALU_SLT     = 4'b1110,
        ALU_DEFAULT = 4'b1111
    } aluOp;

endpackage

/* design/memoryAccess.sv */
module memoryAccess
    import cpuPkg::*;
    import isaPkg::*;
(
    input  cycleState            state,
    input  logic [dataWidth-1:0] pc,
    input  opCode                opcode,
    input  logic [dataWidth-1:0] aluResult,
    input  logic [dataWidth-1:0] rtData,
    input  logic                 waitrequest,
    output logic [dataWidth-1:0] address,
    output logic                 read,
    output logic                 write,
    output logic [dataWidth-1:0] writedata,
    output logic [3:0]           byteenable,
    output logic                 memStall
);

    logic fetchRead;
    logic dataRead;

    // no fetch is issued once the pc reaches the halt address
    assign fetchRead = (state == S_FETCH) && (pc != haltAddress);
    assign dataRead  = (state == S_MEMORY) && (opcode == OP_LW);

    assign read  = fetchRead || dataRead;
    assign write = (state == S_MEMORY) && (opcode == OP_SW);

    assign address    = (state == S_FETCH) ? pc : aluResult;
    assign writedata  = rtData;   // words go out in bus order
    assign byteenable = allLanes;

    // strobes are held until the slave drops waitrequest
    assign memStall = (dataRead || write) && waitrequest;

endmodule

/* design/mipsCpuBus.sv */
module mipsCpuBus
    import cpuPkg::*;
    import isaPkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 waitrequest,
    input  logic [dataWidth-1:0] readdata,
    output logic                 active,
    output logic [dataWidth-1:0] registerV0,
    output logic [dataWidth-1:0] address,
    output logic                 read,
    output logic                 write,
    output logic [dataWidth-1:0] writedata,
    output logic [3:0]           byteenable
);

    cycleState                 state;
    opCode                     opcode;
    fnCode                     funct;
    aluOp                      aluControl;
    logic                      haltFetch;
    logic                      memStall;
    logic                      redirect;
    logic                      writeEnable;
    logic [dataWidth-1:0]      pc;
    logic [dataWidth-1:0]      redirectTarget;
    logic [dataWidth-1:0]      immSigned;
    logic [dataWidth-1:0]      immZero;
    logic [dataWidth-1:0]      rsData;
    logic [dataWidth-1:0]      rtData;
    logic [dataWidth-1:0]      aluResult;
    logic [dataWidth-1:0]      writeData;
    logic [regAddrWidth-1:0]   rsAddr;
    logic [regAddrWidth-1:0]   rtAddr;
    logic [regAddrWidth-1:0]   rdAddr;
    logic [regAddrWidth-1:0]   writeAddr;
    logic [4:0]                shamt;
    logic [jumpIndexWidth-1:0] jumpIndex;

    cycleSequencer u_sequencer (.clk, .reset, .waitrequest, .haltFetch, .memStall,
        .state, .active);

    fetchUnit u_fetch (.clk, .reset, .state, .redirect, .redirectTarget, .pc, .haltFetch);

    decodeUnit u_decode (.clk, .reset, .state, .readdata, .opcode, .funct, .rsAddr,
        .rtAddr, .rdAddr, .shamt, .immSigned, .immZero, .jumpIndex, .aluControl);

    registerFile u_regs (.clk, .reset, .rsAddr, .rtAddr, .writeEnable, .writeAddr,
        .writeData, .rsData, .rtData, .registerV0);

    aluExecute u_execute (.clk, .reset, .state, .opcode, .funct, .aluControl, .rsData,
        .rtData, .immSigned, .immZero, .shamt, .jumpIndex, .pc, .aluResult, .redirect,
        .redirectTarget);

    memoryAccess u_memory (.state, .pc, .opcode, .aluResult, .rtData, .waitrequest,
        .address, .read, .write, .writedata, .byteenable, .memStall);

    writebackUnit u_writeback (.clk, .reset, .state, .opcode, .funct, .rtAddr, .rdAddr,
        .aluResult, .readdata, .pc, .writeEnable, .writeAddr, .writeData);

endmodule

/* design/registerFile.sv */
module registerFile
    import cpuPkg::*;
    import isaPkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic [regAddrWidth-1:0] rsAddr,
    input  logic [regAddrWidth-1:0] rtAddr,
    input  logic                    writeEnable,
    input  logic [regAddrWidth-1:0] writeAddr,
    input  logic [dataWidth-1:0]    writeData,
    output logic [dataWidth-1:0]    rsData,
    output logic [dataWidth-1:0]    rtData,
    output logic [dataWidth-1:0]    registerV0
);

    logic [dataWidth-1:0] regs [2**regAddrWidth];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin   // $zero stays zero
            regs[writeAddr] <= writeData;
        end
    end

    assign rsData = regs[rsAddr];
    assign rtData = regs[rtAddr];
    assign registerV0 = regs[2];   // $v0

endmodule

/* design/writebackUnit.sv */
module writebackUnit
    import cpuPkg::*;
    import isaPkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  cycleState               state,
    input  opCode                   opcode,
    input  fnCode                   funct,
    input  logic [regAddrWidth-1:0] rtAddr,
    input  logic [regAddrWidth-1:0] rdAddr,
    input  logic [dataWidth-1:0]    aluResult,
    input  logic [dataWidth-1:0]    readdata,
    input  logic [dataWidth-1:0]    pc,
    output logic                    writeEnable,
    output logic [regAddrWidth-1:0] writeAddr,
    output logic [dataWidth-1:0]    writeData
);

    logic writesReg;

    always_comb begin
        case (opcode)
            OP_R_TYPE: writesReg = (funct != FN_JR);
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI,
            OP_LUI, OP_LW, OP_JAL: writesReg = 1'b1;
            default:   writesReg = 1'b0;   // SW, J, BEQ, BNE
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) writeEnable <= 1'b0;
        else writeEnable <= (state == S_WRITEBACK) && writesReg;   // lands during next fetch
    end

    always_ff @(posedge clk) begin
        if (state == S_WRITEBACK) begin
            writeAddr <= (opcode == OP_R_TYPE) ? rdAddr :
                         (opcode == OP_JAL)    ? linkRegister : rtAddr;
            writeData <= (opcode == OP_LW)  ? readdata :
                         (opcode == OP_JAL) ? pc + 32'd8 : aluResult;   // link skips the slot
        end
    end

endmodule

/* test/avalonMemory.sv */
module avalonMemory #(
    parameter logic [31:0] progBase = 32'hBFC0_0000,
    parameter logic [31:0] dataBase = 32'h0000_1000,
    parameter int          words    = 64
)(
    input  logic        clk,
    input  logic        stallsOn,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    input  logic [3:0]  byteenable,
    output logic        waitrequest,
    output logic [31:0] readdata
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] progMem [words];
    logic [31:0] dataMem [words];
    logic [31:0] lcgState;

    function automatic logic [31:0] lcgNext(logic [31:0] seed);
        return seed * 32'd1664525 + 32'd1013904223;
    endfunction

    // unmapped and cleared words read back as a function of their address
    function automatic logic [31:0] fillWord(logic [31:0] addr);
        return addr ^ 32'hC3C3_3C3C;
    endfunction

    function automatic logic inRegion(logic [31:0] addr, logic [31:0] base);
        return (addr >= base) && (addr < base + 4 * words);
    endfunction

    function automatic logic [31:0] peekWord(logic [31:0] addr);
        if (inRegion(addr, progBase)) return progMem[(addr - progBase) >> 2];
        else if (inRegion(addr, dataBase)) return dataMem[(addr - dataBase) >> 2];
        else return fillWord(addr);
    endfunction

    task automatic loadWord(logic [31:0] addr, logic [31:0] data);
        if (inRegion(addr, progBase)) progMem[(addr - progBase) >> 2] = data;
        else if (inRegion(addr, dataBase)) dataMem[(addr - dataBase) >> 2] = data;
    endtask

    task automatic clearMemory();
        for (int i = 0; i < words; i++) begin
            progMem[i] = 32'h0000_0000;   // nop
            dataMem[i] = fillWord(dataBase + 4 * i);
        end
    endtask

    initial begin
        lcgState    = 32'h87f2_9bbc;
        waitrequest = 1'b0;
        readdata    = 32'h0000_0000;
    end

    always @(posedge clk) begin
        logic [31:0] merged;
        if (read && !waitrequest) readdata <= peekWord(address);   // valid one cycle later
        if (write && !waitrequest && inRegion(address, dataBase)) begin
            merged = dataMem[(address - dataBase) >> 2];
            for (int b = 0; b < 4; b++) begin
                if (byteenable[b]) merged[8*b +: 8] = writedata[8*b +: 8];
            end
            dataMem[(address - dataBase) >> 2] <= merged;
        end
        lcgState = lcgNext(lcgState);
        waitrequest <= stallsOn && (lcgState[31:29] < 3'd3);   // roughly three in eight cycles
    end

endmodule

/* test/cpuTb.sv */
module cpuTb
    import isaPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] bootAddress = 32'hBFC0_0000;
    localparam logic [31:0] dataBase = 32'h0000_1000;
    localparam int haltTimeout = 4000;
    localparam int resetCycles = 16;

    // register numbers
    localparam logic [4:0] rZero = 5'd0;
    localparam logic [4:0] rV0 = 5'd2;
    localparam logic [4:0] rT0 = 5'd8;
    localparam logic [4:0] rT1 = 5'd9;
    localparam logic [4:0] rT2 = 5'd10;
    localparam logic [4:0] rT3 = 5'd11;
    localparam logic [4:0] rT4 = 5'd12;
    localparam logic [4:0] rT5 = 5'd13;
    localparam logic [4:0] rT6 = 5'd14;
    localparam logic [4:0] rT7 = 5'd15;
    localparam logic [4:0] rS0 = 5'd16;
    localparam logic [4:0] rS1 = 5'd17;
    localparam logic [4:0] rS2 = 5'd18;
    localparam logic [4:0] rS3 = 5'd19;
    localparam logic [4:0] rS4 = 5'd20;
    localparam logic [4:0] rS5 = 5'd21;
    localparam logic [4:0] rS6 = 5'd22;
    localparam logic [4:0] rRa = 5'd31;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        stallsOn = 1'b0;
    logic        waitrequest;
    logic [31:0] readdata;
    logic        active;
    logic [31:0] registerV0;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic [3:0]  byteenable;

    logic [31:0] prog [$];
    string       mode = "no stalls";
    int          errorCount = 0;
    int          checkCount = 0;
    logic        firstReadSeen = 1'b0;
    logic [31:0] firstReadAddr = '0;
    logic [3:0]  firstReadBe = '0;
    logic        zeroRead = 1'b0;
    int          writeCount = 0;
    int          stallCycles = 0;
    logic [31:0] lastWriteAddr = '0;
    logic [31:0] lastWriteData = '0;

    always #20 clk = ~clk;

    mipsCpuBus i_dut (.clk, .reset, .waitrequest, .readdata, .active, .registerV0,
        .address, .read, .write, .writedata, .byteenable);

    avalonMemory #(.progBase(bootAddress), .dataBase(dataBase)) i_mem (.clk, .stallsOn,
        .address, .read, .write, .writedata, .byteenable, .waitrequest, .readdata);

    // bus observer sampling the values settled before each edge
    always @(posedge clk) begin
        if (!reset) begin
            if (read && !waitrequest && !firstReadSeen) begin
                firstReadSeen = 1'b1;
                firstReadAddr = address;
                firstReadBe   = byteenable;
            end
            if (read && address == 32'h0) zeroRead = 1'b1;
            if ((read || write) && waitrequest) stallCycles++;
            if (write && !waitrequest) begin
                writeCount++;
                lastWriteAddr = address;
                lastWriteData = writedata;
            end
        end
    end

    function automatic logic [31:0] rType(fnCode fn, logic [4:0] rd, logic [4:0] rs,
                                          logic [4:0] rt, logic [4:0] sa);
        return {6'b000000, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] iType(opCode op, logic [4:0] rt, logic [4:0] rs,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jType(opCode op, logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    task automatic emit(logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic emitHalt();
        emit(rType(FN_JR, rZero, rZero, rZero, 5'd0));   // jr $zero
        emit(32'h0000_0000);                              // delay slot nop
    endtask

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            $display("CHECK FAILED at %0t (%s): %s expected %h got %h",
                     $time, mode, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic loadProgram();
        i_mem.clearMemory();
        foreach (prog[i]) i_mem.loadWord(bootAddress + 4 * i, prog[i]);
    endtask

    task automatic resetDut();
        @(posedge clk);
        reset <= 1'b1;
        repeat (resetCycles) @(posedge clk);
        firstReadSeen = 1'b0;
        zeroRead      = 1'b0;
        writeCount    = 0;
        reset <= 1'b0;
    endtask

    task automatic waitForHalt(string name);
        int cycles;
        cycles = 0;
        while (active === 1'b1 && cycles < haltTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (active !== 1'b0) begin
            $display("%s test (%s): the CPU did not halt within %0d cycles",
                     name, mode, haltTimeout);
            errorCount++;
        end
    endtask

    task automatic resetTest();
        prog.delete();
        emitHalt();
        loadProgram();
        resetDut();
        @(negedge clk);
        checkValue("active", 32'd1, {31'd0, active});
        checkValue("read", 32'd1, {31'd0, read});
        checkValue("write", 32'd0, {31'd0, write});
        checkValue("address", bootAddress, address);
        checkValue("byteenable", 32'hF, {28'd0, byteenable});
        waitForHalt("reset");
        checkValue("first read address", bootAddress, firstReadAddr);
        checkValue("first read byteenable", 32'hF, {28'd0, firstReadBe});
    endtask

    task automatic arithmeticTest();
        logic [31:0] t0, t1, t2, t3, t4, t5, s1, s2, s3, s5, s6, flags, v0;
        prog.delete();
        emit(iType(OP_LUI, rT0, rZero, 16'h1234));
        emit(iType(OP_ORI, rT0, rT0, 16'h5678));
        emit(iType(OP_ADDIU, rT1, rZero, 16'hFFFB));   // -5
        emit(rType(FN_ADDU, rT2, rT0, rT1, 5'd0));
        emit(rType(FN_SUBU, rT3, rT0, rT1, 5'd0));
        emit(rType(FN_AND, rT4, rT2, rT3, 5'd0));
        emit(rType(FN_XOR, rT5, rT2, rT3, 5'd0));
        emit(rType(FN_SLT, rT6, rT1, rT0, 5'd0));
        emit(rType(FN_SLL, rT6, rZero, rT6, 5'd3));
        emit(rType(FN_SLTU, rT7, rT1, rT0, 5'd0));
        emit(rType(FN_SLL, rT7, rZero, rT7, 5'd2));
        emit(iType(OP_SLTI, rS0, rT1, 16'hFFFD));
        emit(rType(FN_SLL, rS0, rZero, rS0, 5'd1));
        emit(iType(OP_SLTIU, rS4, rT1, 16'hFFFF));     // immediate sign-extends
        emit(rType(FN_SLL, rS1, rZero, rT0, 5'd4));
        emit(rType(FN_SRL, rS2, rZero, rT1, 5'd8));
        emit(rType(FN_SRA, rS3, rZero, rT1, 5'd2));
        emit(iType(OP_ANDI, rS5, rT0, 16'hF0F0));
        emit(iType(OP_XORI, rS6, rT1, 16'h00FF));
        emit(rType(FN_ADDU, rV0, rT4, rT5, 5'd0));
        emit(rType(FN_XOR, rV0, rV0, rS1, 5'd0));
        emit(rType(FN_SUBU, rV0, rV0, rS2, 5'd0));
        emit(rType(FN_ADDU, rV0, rV0, rS3, 5'd0));
        emit(rType(FN_XOR, rV0, rV0, rS5, 5'd0));
        emit(rType(FN_ADDU, rV0, rV0, rS6, 5'd0));
        emit(rType(FN_ADDU, rV0, rV0, rT6, 5'd0));
        emit(rType(FN_ADDU, rV0, rV0, rT7, 5'd0));
        emit(rType(FN_ADDU, rV0, rV0, rS0, 5'd0));
        emit(rType(FN_ADDU, rV0, rV0, rS4, 5'd0));
        emitHalt();
        loadProgram();
        resetDut();
        waitForHalt("arithmetic");
        t0 = 32'h1234_5678;
        t1 = 32'hFFFF_FFFB;
        t2 = t0 + t1;
        t3 = t0 - t1;
        t4 = t2 & t3;
        t5 = t2 ^ t3;
        s1 = t0 << 4;
        s2 = t1 >> 8;
        s3 = $signed(t1) >>> 2;
        s5 = t0 & 32'h0000_F0F0;   // logical immediates zero-extend
        s6 = t1 ^ 32'h0000_00FF;
        flags = (($signed(t1) < $signed(t0)) ? 32'd8 : 32'd0)
              + ((t1 < t0) ? 32'd4 : 32'd0)
              + (($signed(t1) < -3) ? 32'd2 : 32'd0)
              + ((t1 < 32'hFFFF_FFFF) ? 32'd1 : 32'd0);
        v0 = ((((t4 + t5) ^ s1) - s2 + s3) ^ s5) + s6 + flags;
        checkValue("registerV0", v0, registerV0);
    endtask

    task automatic loadStoreTest();
        prog.delete();
        emit(iType(OP_ADDIU, rT0, rZero, 16'h1010));     // base above the target word
        emit(iType(OP_LUI, rT1, rZero, 16'hCAFE));
        emit(iType(OP_ORI, rT1, rT1, 16'hF00D));
        emit(iType(OP_SW, rT1, rT0, 16'hFFF8));          // offset -8
        emit(iType(OP_LW, rV0, rT0, 16'hFFF8));
        emitHalt();
        loadProgram();
        resetDut();
        waitForHalt("load/store");
        checkValue("registerV0", 32'hCAFE_F00D, registerV0);
        checkValue("write count", 32'd1, writeCount);
        checkValue("write address", 32'h0000_1010 - 32'd8, lastWriteAddr);
        checkValue("writedata", 32'hCAFE_F00D, lastWriteData);
        checkValue("memory word 0x1008", 32'hCAFE_F00D, i_mem.peekWord(32'h0000_1008));
        checkValue("memory word 0x100c", 32'h0000_100C ^ 32'hC3C3_3C3C,
                   i_mem.peekWord(32'h0000_100C));
    endtask

    task automatic branchTest();
        prog.delete();
        emit(iType(OP_ADDIU, rT0, rZero, 16'd7));
        emit(iType(OP_ADDIU, rT1, rZero, 16'd7));
        emit(iType(OP_ADDIU, rV0, rZero, 16'd0));
        emit(iType(OP_BEQ, rT1, rT0, 16'd2));       // taken to word 6
        emit(iType(OP_ADDIU, rV0, rV0, 16'h0001));  // delay slot
        emit(iType(OP_ADDIU, rV0, rV0, 16'h0100));  // skipped
        emit(iType(OP_BNE, rT1, rT0, 16'd2));       // not taken
        emit(iType(OP_ADDIU, rV0, rV0, 16'h0010));
        emit(iType(OP_ADDIU, rV0, rV0, 16'h0020));
        emitHalt();
        loadProgram();
        resetDut();
        waitForHalt("branch");
        checkValue("registerV0", 32'h1 + 32'h10 + 32'h20, registerV0);
    endtask

    task automatic jumpHaltTest();
        logic [31:0] link;
        prog.delete();
        emit(iType(OP_ADDIU, rV0, rZero, 16'd0));
        emit(jType(OP_JAL, bootAddress + 4 * 12));
        emit(iType(OP_ADDIU, rT0, rZero, 16'd5));   // delay slot of jal
        emit(rType(FN_ADDU, rV0, rV0, rT0, 5'd0));  // return lands here
        emit(jType(OP_J, bootAddress + 4 * 10));
        emit(rType(FN_XOR, rV0, rV0, rRa, 5'd0));   // delay slot of j
        emit(iType(OP_ADDIU, rV0, rV0, 16'h7000));  // skipped
        emit(32'h0000_0000);
        emit(32'h0000_0000);
        emit(32'h0000_0000);
        emitHalt();                                  // words 10 and 11
        emit(iType(OP_ADDIU, rV0, rV0, 16'h0040));  // subroutine
        emit(rType(FN_JR, rZero, rRa, rZero, 5'd0));
        emit(iType(OP_ADDIU, rV0, rV0, 16'h0200));  // delay slot of jr
        loadProgram();
        resetDut();
        waitForHalt("jump");
        link = bootAddress + 32'd4 + 32'd8;
        checkValue("registerV0", (32'h240 + 32'd5) ^ link, registerV0);
        @(negedge clk);
        checkValue("active", 32'd0, {31'd0, active});
        checkValue("read", 32'd0, {31'd0, read});
        assert (!zeroRead) else begin
            $display("jump test (%s): a read was issued at address zero", mode);
            errorCount++;
        end
    endtask

    task automatic runPrograms();
        arithmeticTest();
        loadStoreTest();
        branchTest();
        jumpHaltTest();
    endtask

    initial begin
        resetTest();
        runPrograms();
        @(posedge clk);
        stallsOn <= 1'b1;
        mode = "random stalls";
        stallCycles = 0;   // the CPU is halted so no strobe is active here
        runPrograms();
        assert (stallCycles > 0) else begin
            $display("no waitrequest stall was seen during the stall run");
            errorCount++;
        end
        $display("checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
